// ==== compile.f ====
+incdir+tests
hw/core_pkg.sv
hw/bridge_read_mux.sv
hw/slot_state.sv
hw/datatable_poller.sv
hw/pll_reconfig_seq.sv
hw/core_top.sv
tests/tb_core_top.sv

// ==== tests/tb_tasks.svh ====
//////////////////////////////////////////////////////////////////////
// value check and bounded waits for the core_top testbench
// LCG random source and the expected PLL write table
//////////////////////////////////////////////////////////////////////

`ifndef tb_tasks_svh
`define tb_tasks_svh

  // LCG state, fixed seed
  logic [31:0] lcg_state = 32'd21406;

  // expected PLL writes, address then NTSC and PAL data
  localparam logic [5:0] exp_pll_addr [8] = '{
    6'd0, 6'd7, 6'd5, 6'd5, 6'd5, 6'd5, 6'd4, 6'd2
  };
  localparam logic [31:0] exp_pll_ntsc [8] = '{
    32'd0, 32'd425937894, 32'h0002_0403, 32'h0004_0e0e,
    32'h0008_1c1c, 32'h000c_1c1c, 32'h0000_0404, 32'd0
  };
  localparam logic [31:0] exp_pll_pal [8] = '{
    32'd0, 32'd737741702, 32'h0000_0404, 32'h0004_1010,
    32'h0008_2020, 32'h000c_2020, 32'h0002_0504, 32'd0
  };

  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      abort_run($sformatf("FAIL %s got 0x%h expected 0x%h", name, actual, expected));
    end
  endtask

  // returns on the first falling edge with the write strobe at level
  task automatic wait_for_wren(input logic level, input int limit);
    int cycles;
    cycles = 0;
    while (datatable_wren !== level) begin
      if (cycles == limit) begin
        abort_run($sformatf("datatable_wren did not go to %0b within %0d cycles",
                            level, limit));
      end
      @(negedge clk_74a);
      cycles++;
    end
  endtask

  task automatic wait_for_rom_size(input logic [31:0] expected, input int limit);
    int cycles;
    cycles = 0;
    @(negedge clk_74a);
    while (rom_file_size !== expected) begin
      if (cycles == limit) begin
        abort_run($sformatf("rom_file_size did not pick up the table value in %0d cycles",
                            limit));
      end
      @(negedge clk_74a);
      cycles++;
    end
  endtask

`endif

// ==== tests/tb_core_top.sv ====
//////////////////////////////////////////////////////////////////////
// testbench for core_top
// directed tests of the bridge read mux, slot flags, data-table poll
// and PLL reconfiguration with back-pressure
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module tb_core_top;

  import core_pkg::*;

  logic        clk_74a;
  logic        pll_core_locked;
  word_t       bridge_addr;
  word_t       cmd_rd_data;
  word_t       save_rd_data;
  word_t       bridge_rd_data;
  logic        dataslot_requestread;
  logic        dataslot_requestwrite;
  logic        dataslot_allcomplete;
  logic        ioctl_download;
  logic        save_download;
  word_t       datatable_q;
  sram_size_t  sram_size;
  table_addr_t datatable_addr;
  logic        datatable_wren;
  word_t       datatable_data;
  word_t       rom_file_size;
  logic        pal;
  logic        cfg_waitrequest;
  logic        cfg_write;
  cfg_addr_t   cfg_address;
  word_t       cfg_data;

  // slot 1 length held by the table model
  word_t       rom_len;

  `include "tb_tasks.svh"

  core_top dut (
    .clk_74a               (clk_74a),
    .pll_core_locked       (pll_core_locked),
    .bridge_addr           (bridge_addr),
    .cmd_rd_data           (cmd_rd_data),
    .save_rd_data          (save_rd_data),
    .bridge_rd_data        (bridge_rd_data),
    .dataslot_requestread  (dataslot_requestread),
    .dataslot_requestwrite (dataslot_requestwrite),
    .dataslot_allcomplete  (dataslot_allcomplete),
    .ioctl_download        (ioctl_download),
    .save_download         (save_download),
    .datatable_q           (datatable_q),
    .sram_size             (sram_size),
    .datatable_addr        (datatable_addr),
    .datatable_wren        (datatable_wren),
    .datatable_data        (datatable_data),
    .rom_file_size         (rom_file_size),
    .pal                   (pal),
    .cfg_waitrequest       (cfg_waitrequest),
    .cfg_write             (cfg_write),
    .cfg_address           (cfg_address),
    .cfg_data              (cfg_data)
  );

  // 50 MHz stand-in for the host clock
  always #10 clk_74a = ~clk_74a;

  // data table model, slot length at address 1
  always @(negedge clk_74a) begin
    if (datatable_addr == 10'd1) begin
      datatable_q <= rom_len;
    end else begin
      datatable_q <= ~rom_len;
    end
  end

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("TEST FAILED");
    $fatal(1);
  endtask

  //////////////////////////////////////////////////////////////////////
  // directed tests

  task automatic test_bridge_read();
    int    i;
    word_t addr;
    word_t expected;
    for (i = 0; i < 30; i++) begin
      addr = next_rand();
      // cycle through save, command and unmapped addresses
      if (i % 3 == 0) begin
        addr[31:28] = 4'h2;
      end else if (i % 3 == 1) begin
        addr[31:24] = 8'hf8;
      end else if (addr[31:28] == 4'h2 || addr[31:24] == 8'hf8) begin
        addr[31:28] = 4'h7;
      end
      @(negedge clk_74a);
      bridge_addr  = addr;
      cmd_rd_data  = next_rand();
      save_rd_data = next_rand();
      // save region first, then command region, else zero
      if (addr[31:28] == 4'h2) begin
        expected = save_rd_data;
      end else if (addr[31:24] == 8'hf8) begin
        expected = cmd_rd_data;
      end else begin
        expected = '0;
      end
      // mid-cycle, mux output has settled
      #5;
      check_value("bridge_rd_data", bridge_rd_data, expected);
    end
  endtask

  // drive the three strobes for one cycle, called on a falling edge
  task automatic drive_slot(input logic rd, input logic wr, input logic done);
    dataslot_requestread  = rd;
    dataslot_requestwrite = wr;
    dataslot_allcomplete  = done;
    @(negedge clk_74a);
  endtask

  task automatic check_flags(input logic exp_ioctl, input logic exp_save);
    check_value("ioctl_download", 32'(ioctl_download), 32'(exp_ioctl));
    check_value("save_download", 32'(save_download), 32'(exp_save));
  endtask

  task automatic test_slot_flags();
    @(negedge clk_74a);
    check_flags(1'b0, 1'b0);
    drive_slot(1'b0, 1'b1, 1'b0);
    check_flags(1'b1, 1'b1);
    drive_slot(1'b0, 1'b0, 1'b1);
    check_flags(1'b0, 1'b0);
    drive_slot(1'b1, 1'b0, 1'b0);
    check_flags(1'b0, 1'b1);
    drive_slot(1'b0, 1'b0, 1'b0);
    check_flags(1'b0, 1'b1);
    // completion held high, then a new read request on top of it
    drive_slot(1'b0, 1'b0, 1'b1);
    check_flags(1'b0, 1'b0);
    drive_slot(1'b1, 1'b0, 1'b1);
    check_flags(1'b0, 1'b1);
    drive_slot(1'b0, 1'b0, 1'b1);
    check_flags(1'b0, 1'b1);
    drive_slot(1'b0, 1'b0, 1'b1);
    check_flags(1'b0, 1'b1);
    // only a fresh edge closes the save window
    drive_slot(1'b0, 1'b0, 1'b0);
    check_flags(1'b0, 1'b1);
    drive_slot(1'b0, 1'b0, 1'b1);
    check_flags(1'b0, 1'b0);
    // write request beats completion in the same cycle
    drive_slot(1'b0, 1'b1, 1'b1);
    check_flags(1'b1, 1'b1);
    drive_slot(1'b0, 1'b0, 1'b0);
    check_flags(1'b1, 1'b1);
    drive_slot(1'b0, 1'b0, 1'b1);
    check_flags(1'b0, 1'b0);
    drive_slot(1'b0, 1'b0, 1'b0);
  endtask

  task automatic test_table_write();
    int    code;
    int    seen;
    word_t expected;
    for (code = 0; code < 16; code++) begin
      @(negedge clk_74a);
      sram_size = 4'(code);
      // code 0 is no save RAM, else 1 KiB doubled per step
      expected = (code == 0) ? 32'd0 : (32'd1024 << code);
      // skip a burst captured before the new code
      wait_for_wren(1'b0, 16);
      wait_for_wren(1'b1, 16);
      seen = 0;
      while (datatable_wren === 1'b1 && seen < 8) begin
        check_value("datatable_addr", 32'(datatable_addr), 32'd3);
        check_value("datatable_data", datatable_data, expected);
        seen++;
        @(negedge clk_74a);
      end
      // three write phases out of eight
      check_value("datatable_wren burst length", 32'(seen), 32'd3);
    end
  endtask

  task automatic test_rom_size();
    int n;
    for (n = 0; n < 4; n++) begin
      // set away from the falling edge the table model runs on
      @(posedge clk_74a);
      rom_len = next_rand();
      wait_for_rom_size(rom_len, 16);
    end
  endtask

  // toggle the standard and follow the eight writes
  // stall_after = 0 means the config port never stalls
  task automatic run_pll_sequence(input logic new_pal, input int stall_after,
                                  input int stall_len);
    int count;
    int cycles;
    int k;
    count  = 0;
    cycles = 0;
    @(negedge clk_74a);
    pal = new_pal;
    while (count < 8) begin
      if (cycles == 200) begin
        abort_run("timeout waiting for the eight cfg_write strobes");
      end
      @(negedge clk_74a);
      cycles++;
      if (cfg_write === 1'b1) begin
        check_value("cfg_address", 32'(cfg_address), 32'(exp_pll_addr[count]));
        check_value("cfg_data", cfg_data,
                    new_pal ? exp_pll_pal[count] : exp_pll_ntsc[count]);
        count++;
        if (count == stall_after) begin
          // let the gap step pass, so the stall lands on a write step
          @(negedge clk_74a);
          check_value("cfg_write", 32'(cfg_write), 32'd0);
          // config port busy, nothing may be written
          cfg_waitrequest = 1'b1;
          for (k = 0; k < stall_len; k++) begin
            @(negedge clk_74a);
            if (cfg_write !== 1'b0) begin
              abort_run("cfg_write asserted while cfg_waitrequest was high");
            end
          end
          cfg_waitrequest = 1'b0;
        end
      end
    end
    // sequence must stop after the start write
    for (k = 0; k < 20; k++) begin
      @(negedge clk_74a);
      if (cfg_write !== 1'b0) begin
        abort_run("extra cfg_write after the eighth write of the sequence");
      end
    end
  endtask

  task automatic test_back_pressure();
    int stall_after;
    int stall_len;
    stall_after = 2 + int'(next_rand() % 32'd5);
    stall_len   = 4 + int'(next_rand() % 32'd16);
    run_pll_sequence(1'b1, stall_after, stall_len);
  endtask

  initial begin
    clk_74a               = 1'b0;
    pll_core_locked       = 1'b0;
    bridge_addr           = '0;
    cmd_rd_data           = '0;
    save_rd_data          = '0;
    dataslot_requestread  = 1'b0;
    dataslot_requestwrite = 1'b0;
    dataslot_allcomplete  = 1'b0;
    datatable_q           = '0;
    sram_size             = '0;
    pal                   = 1'b0;
    cfg_waitrequest       = 1'b0;
    rom_len               = '0;
    // reset over 5 rising edges
    repeat (5) @(posedge clk_74a);
    @(negedge clk_74a);
    pll_core_locked = 1'b1;

    test_bridge_read();
    test_slot_flags();
    test_table_write();
    test_rom_size();
    // NTSC to PAL and back, then PAL again under a stall
    run_pll_sequence(1'b1, 0, 0);
    run_pll_sequence(1'b0, 0, 0);
    test_back_pressure();

    $display("TEST OK");
    $finish;
  end

endmodule

`default_nettype wire

// ==== hw/core_top.sv ====
//////////////////////////////////////////////////////////////////////
// host clock domain control top level
// bridge read mux, slot flags, data-table poll, PLL reconfig
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module core_top (
  input  wire clk_74a,
  input  wire pll_core_locked,

  // bridge read path
  input  wire core_pkg::word_t       bridge_addr,
  input  wire core_pkg::word_t       cmd_rd_data,
  input  wire core_pkg::word_t       save_rd_data,
  output wire core_pkg::word_t       bridge_rd_data,

  // data-slot strobes from the command bridge
  input  wire dataslot_requestread,
  input  wire dataslot_requestwrite,
  input  wire dataslot_allcomplete,
  output wire ioctl_download,
  output wire save_download,

  // data-table port
  input  wire core_pkg::word_t       datatable_q,
  input  wire core_pkg::sram_size_t  sram_size,
  output wire core_pkg::table_addr_t datatable_addr,
  output wire datatable_wren,
  output wire core_pkg::word_t       datatable_data,
  output wire core_pkg::word_t       rom_file_size,

  // PLL config port
  input  wire pal,
  input  wire cfg_waitrequest,
  output wire cfg_write,
  output wire core_pkg::cfg_addr_t   cfg_address,
  output wire core_pkg::word_t       cfg_data
);

  // read data steering, combinational
  bridge_read_mux u_bridge_read_mux (
    .bridge_addr    (bridge_addr),
    .cmd_rd_data    (cmd_rd_data),
    .save_rd_data   (save_rd_data),
    .bridge_rd_data (bridge_rd_data)
  );

  // ROM and save transfer flags
  slot_state u_slot_state (
    .clk_74a               (clk_74a),
    .pll_core_locked       (pll_core_locked),
    .dataslot_requestread  (dataslot_requestread),
    .dataslot_requestwrite (dataslot_requestwrite),
    .dataslot_allcomplete  (dataslot_allcomplete),
    .ioctl_download        (ioctl_download),
    .save_download         (save_download)
  );

  // table port shared between ROM length and save size
  datatable_poller u_datatable_poller (
    .clk_74a         (clk_74a),
    .pll_core_locked (pll_core_locked),
    .datatable_q     (datatable_q),
    .sram_size       (sram_size),
    .datatable_addr  (datatable_addr),
    .datatable_wren  (datatable_wren),
    .datatable_data  (datatable_data),
    .rom_file_size   (rom_file_size)
  );

  // NTSC / PAL clock switch
  pll_reconfig_seq u_pll_reconfig_seq (
    .clk_74a         (clk_74a),
    .pll_core_locked (pll_core_locked),
    .pal             (pal),
    .cfg_waitrequest (cfg_waitrequest),
    .cfg_write       (cfg_write),
    .cfg_address     (cfg_address),
    .cfg_data        (cfg_data)
  );

endmodule

`default_nettype wire

// ==== hw/pll_reconfig_seq.sv ====
//////////////////////////////////////////////////////////////////////
// PLL reconfiguration sequencer
// syncs the PAL flag, restarts on each video standard change
// walks the eight-entry write table under waitrequest
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module pll_reconfig_seq (
  input  wire  clk_74a,
  input  wire  pll_core_locked,
  input  wire  pal,
  input  wire  cfg_waitrequest,
  output logic                  cfg_write,
  output core_pkg::cfg_addr_t   cfg_address,
  output core_pkg::word_t       cfg_data
);

  import core_pkg::*;

  //////////////////////////////////////////////////////////////////////
  // PAL flag synchronizer

  // two stages; a mismatch between them marks a change
  logic pal_meta;
  logic pal_sync;
  logic pal_change;

  assign pal_change = (pal_meta != pal_sync);

  //////////////////////////////////////////////////////////////////////
  // step counter

  // 0 is idle, odd steps issue a write, even steps are gaps
  pll_step_t   step;
  logic [2:0]  table_idx;
  logic        issue;

  // (step - 1) / 2 for odd steps
  assign table_idx = step[3:1];
  assign issue     = step[0] & ~cfg_waitrequest;

  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      pal_meta  <= 1'b0;
      pal_sync  <= 1'b0;
      step      <= '0;
      cfg_write <= 1'b0;
    end else begin
      pal_meta <= pal;
      pal_sync <= pal_meta;

      // write strobe lasts a single cycle
      cfg_write <= issue;

      // hold everything while the config port stalls
      if (!cfg_waitrequest && step != '0) begin
        // 15 wraps back to idle after the final start write
        step <= step + 4'd1;
      end

      // a new standard restarts from the first write
      if (pal_change) begin
        step <= 4'd1;
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // write payload

  always_ff @(posedge clk_74a) begin
    if (issue) begin
      cfg_address <= pll_addr_table[table_idx];
      // synced flag picks the standard
      if (pal_sync) begin
        cfg_data <= pll_pal_table[table_idx];
      end else begin
        cfg_data <= pll_ntsc_table[table_idx];
      end
    end
  end

endmodule

`default_nettype wire

// ==== hw/datatable_poller.sv ====
//////////////////////////////////////////////////////////////////////
// data-table poller
// eight-phase share of the table port
// reads the ROM length, publishes the save RAM size in bytes
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module datatable_poller (
  input  wire  clk_74a,
  input  wire  pll_core_locked,
  input  wire  core_pkg::word_t      datatable_q,
  input  wire  core_pkg::sram_size_t sram_size,
  output core_pkg::table_addr_t      datatable_addr,
  output logic                       datatable_wren,
  output core_pkg::word_t            datatable_data,
  output core_pkg::word_t            rom_file_size
);

  import core_pkg::*;

  // free-running phase, wraps every 8 cycles
  poll_phase_t phase;
  logic        write_phase;
  // save RAM size in bytes
  word_t       sram_bytes;

  assign write_phase = (phase >= poll_write_phase);
  assign sram_bytes  = (sram_size != '0) ? (word_t'(sram_size_unit) << sram_size) : '0;

  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      phase          <= '0;
      datatable_wren <= 1'b0;
      datatable_addr <= '0;
      rom_file_size  <= '0;
    end else begin
      phase <= phase + 3'd1;

      if (write_phase) begin
        // phases 5..7 write the size entry
        datatable_wren <= 1'b1;
        datatable_addr <= sram_size_entry;
      end else begin
        // rest of the time point at the slot length
        datatable_wren <= 1'b0;
        datatable_addr <= rom_size_entry;
      end

      // table has had a few cycles to return the length
      if (phase == poll_capture_phase) begin
        rom_file_size <= datatable_q;
      end
    end
  end

  // write payload, only meaningful with wren
  always_ff @(posedge clk_74a) begin
    if (write_phase) begin
      datatable_data <= sram_bytes;
    end
  end

endmodule

`default_nettype wire

// ==== hw/slot_state.sv ====
//////////////////////////////////////////////////////////////////////
// data-slot transfer flags
// ioctl_download for ROM loads, save_download for save traffic
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module slot_state (
  input  wire  clk_74a,
  input  wire  pll_core_locked,
  input  wire  dataslot_requestread,
  input  wire  dataslot_requestwrite,
  input  wire  dataslot_allcomplete,
  output logic ioctl_download,
  output logic save_download
);

  // previous allcomplete, for edge detect
  logic allcomplete_prev;
  logic allcomplete_rise;

  assign allcomplete_rise = dataslot_allcomplete & ~allcomplete_prev;

  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      allcomplete_prev <= 1'b0;
      ioctl_download   <= 1'b0;
      save_download    <= 1'b0;
    end else begin
      allcomplete_prev <= dataslot_allcomplete;

      // host write request means a ROM is coming in
      if (dataslot_requestwrite) begin
        ioctl_download <= 1'b1;
      end else if (dataslot_allcomplete) begin
        ioctl_download <= 1'b0;
      end

      // any request opens the save window
      // only a fresh completion edge closes it
      if (dataslot_requestread || dataslot_requestwrite) begin
        save_download <= 1'b1;
      end else if (allcomplete_rise) begin
        save_download <= 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

// ==== hw/bridge_read_mux.sv ====
//////////////////////////////////////////////////////////////////////
// bridge read data mux
// save region has priority over the command region
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module bridge_read_mux (
  input  wire core_pkg::word_t bridge_addr,
  input  wire core_pkg::word_t cmd_rd_data,
  input  wire core_pkg::word_t save_rd_data,
  output core_pkg::word_t      bridge_rd_data
);

  import core_pkg::*;

  // region hits, decoded from the top address bits
  logic save_hit;
  logic cmd_hit;

  assign save_hit = (bridge_addr[31:28] == save_region);
  assign cmd_hit  = (bridge_addr[31:24] == cmd_region);

  // bridge samples on its own schedule, so no register here
  always_comb begin
    if (save_hit) begin
      bridge_rd_data = save_rd_data;
    end else if (cmd_hit) begin
      bridge_rd_data = cmd_rd_data;
    end else begin
      // unmapped reads return zero
      bridge_rd_data = '0;
    end
  end

endmodule

`default_nettype wire

// ==== hw/core_pkg.sv ====
//////////////////////////////////////////////////////////////////////
// shared types for the host clock domain control logic
// bridge region codes, data-table entries, poll phases
// PLL reconfiguration write tables for NTSC and PAL
//////////////////////////////////////////////////////////////////////

`default_nettype none

package core_pkg;

  // bridge, data-table and PLL config data are all one word
  typedef logic [31:0] word_t;
  typedef logic [9:0]  table_addr_t;
  typedef logic [5:0]  cfg_addr_t;
  // save RAM size code from the ROM header
  typedef logic [3:0]  sram_size_t;
  typedef logic [2:0]  poll_phase_t;
  typedef logic [3:0]  pll_step_t;

  //////////////////////////////////////////////////////////////////////
  // bridge address map

  // compared with addr[31:28]
  localparam logic [3:0] save_region = 4'h2;
  // compared with addr[31:24]
  localparam logic [7:0] cmd_region = 8'hf8;

  //////////////////////////////////////////////////////////////////////
  // data table

  // length of data slot 1 (slot index, not id)
  localparam table_addr_t rom_size_entry = 10'd1;
  // size field of data slot 1
  localparam table_addr_t sram_size_entry = 10'd3;
  // bytes per size step, code 0 means no save RAM
  localparam int unsigned sram_size_unit = 1024;
  // phases 5..7 write, phase 4 captures the read
  localparam poll_phase_t poll_write_phase = 3'd5;
  localparam poll_phase_t poll_capture_phase = 3'd4;

  //////////////////////////////////////////////////////////////////////
  // PLL reconfiguration

  localparam int unsigned pll_write_count = 8;

  // mode, fractional M, C0..C3, M counter, start
  localparam cfg_addr_t pll_addr_table [pll_write_count] = '{
    6'd0, 6'd7, 6'd5, 6'd5, 6'd5, 6'd5, 6'd4, 6'd2
  };

  // mem 85.909, main 21.477 MHz
  localparam word_t pll_ntsc_table [pll_write_count] = '{
    32'd0, 32'd425937894, 32'h020403, 32'h040e0e,
    32'h081c1c, 32'h0c1c1c, 32'h00404, 32'd0
  };

  // mem 85.125, main 21.281 MHz
  localparam word_t pll_pal_table [pll_write_count] = '{
    32'd0, 32'd737741702, 32'h000404, 32'h041010,
    32'h082020, 32'h0c2020, 32'h20504, 32'd0
  };

endpackage

`default_nettype wire
